//--- files.f
src/tcdm_pkg.sv
src/tcdm_bus_if.sv
src/mem_wide_narrow_mux.sv
src/tcdm_bank.sv
src/tcdm_subsystem.sv
verification/tb_tcdm_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Builds the TCDM testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -f files.f --top-module tb_tcdm_subsystem \
  -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vtb_tcdm_subsystem > sim.log 2>&1 \
  || { cat build.log; echo "ERRORS FOUND" >> sim.log; }

cat sim.log
grep -q "ERRORS FOUND" sim.log \
  && { echo "Simulation failed"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }

//--- src/mem_wide_narrow_mux.sv
// Static priority mux: wide first, then external, then narrow port i onto bank i.
// Banks must grant at once whenever wide or external is valid; no back-pressure there.
// Responses come MemoryLatency cycles after acceptance and go to the recorded owner.
`timescale 1ns/1ps

module mem_wide_narrow_mux import tcdm_pkg::*; #(
  // Words per bank.
  parameter int unsigned BankWords     = 64,
  // Fixed read latency of the banks.
  parameter int unsigned MemoryLatency = 1,
  localparam int unsigned AddrW        = $clog2(BankWords)
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // Narrow side, one port per bank.
  input  logic         [NR_BANKS-1:0]            narrow_valid_i,
  input  logic         [NR_BANKS-1:0]            narrow_write_i,
  input  logic         [NR_BANKS-1:0][AddrW-1:0] narrow_addr_i,
  input  narrow_data_t [NR_BANKS-1:0]            narrow_data_i,
  input  narrow_strb_t [NR_BANKS-1:0]            narrow_strb_i,
  output logic         [NR_BANKS-1:0]            narrow_ready_o,
  output logic         [NR_BANKS-1:0]            narrow_rvalid_o,
  output narrow_data_t [NR_BANKS-1:0]            narrow_rdata_o,
  // Wide side.
  input  logic                             wide_valid_i,
  input  logic                             wide_write_i,
  input  logic       [AddrW-1:0]           wide_addr_i,
  input  wide_data_u                       wide_data_i,
  input  wide_strb_u                       wide_strb_i,
  output logic                             wide_ready_o,
  output logic                             wide_rvalid_o,
  output wide_data_u                       wide_rdata_o,
  // External side.
  input  logic                             ext_valid_i,
  input  logic                             ext_write_i,
  input  logic       [AddrW-1:0]           ext_addr_i,
  input  wide_data_u                       ext_data_i,
  input  wide_strb_u                       ext_strb_i,
  output logic                             ext_ready_o,
  output logic                             ext_rvalid_o,
  output wide_data_u                       ext_rdata_o,
  // Bank side.
  tcdm_bus_if.requester                    bank [NR_BANKS]
);

  // Owner tags carried with each accepted request.
  localparam logic [1:0] OWN_NONE   = 2'd0;
  localparam logic [1:0] OWN_NARROW = 2'd1;
  localparam logic [1:0] OWN_WIDE   = 2'd2;
  localparam logic [1:0] OWN_EXT    = 2'd3;

  // Per-bank response hits for the wide and external owners.
  logic [NR_BANKS-1:0] wide_hit;
  logic [NR_BANKS-1:0] ext_hit;
  // Read data from all banks, lane by lane.
  narrow_data_t [NR_BANKS-1:0] bank_rdata;

  // --------------------------------------------------------------------------
  // Grants.
  // --------------------------------------------------------------------------

  // Wide always wins.
  assign wide_ready_o = wide_valid_i;
  // External only when wide is idle.
  assign ext_ready_o  = ext_valid_i & ~wide_valid_i;

  for (genvar i = 0; i < NR_BANKS; i++) begin : gen_bank
    logic                            accept;
    logic [1:0]                      owner_d;
    logic [MemoryLatency-1:0][1:0]   owner_q;
    logic [1:0]                      owner_tail;

    // ------------------------------------------------------------------------
    // Forward channel.
    // ------------------------------------------------------------------------
    always_comb begin
      // Narrow request passes through by default.
      bank[i].q_valid = narrow_valid_i[i];
      bank[i].q_addr  = narrow_addr_i[i];
      bank[i].q_write = narrow_write_i[i];
      bank[i].q_data  = narrow_data_i[i];
      bank[i].q_strb  = narrow_strb_i[i];
      owner_d         = OWN_NARROW;
      if (wide_valid_i) begin
        // Wide takes every bank, one lane each.
        bank[i].q_valid = 1'b1;
        bank[i].q_addr  = wide_addr_i;
        bank[i].q_write = wide_write_i;
        bank[i].q_data  = wide_data_i.lane[i];
        bank[i].q_strb  = wide_strb_i.lane[i];
        owner_d         = OWN_WIDE;
      end else if (ext_valid_i) begin
        // External next, same lane split.
        bank[i].q_valid = 1'b1;
        bank[i].q_addr  = ext_addr_i;
        bank[i].q_write = ext_write_i;
        bank[i].q_data  = ext_data_i.lane[i];
        bank[i].q_strb  = ext_strb_i.lane[i];
        owner_d         = OWN_EXT;
      end
    end

    // Narrow port is blocked while a wide source holds the banks.
    assign narrow_ready_o[i] = narrow_valid_i[i] & bank[i].q_ready & ~wide_valid_i
                               & ~ext_valid_i;

    assign accept = bank[i].q_valid & bank[i].q_ready;

    // ------------------------------------------------------------------------
    // Owner pipeline.
    // ------------------------------------------------------------------------
    // Stage 0 takes the tag of this cycle's accepted request.
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        owner_q <= '0;
      end else begin
        owner_q[0] <= accept ? owner_d : OWN_NONE;
        for (int s = 1; s < MemoryLatency; s++) begin
          owner_q[s] <= owner_q[s-1];
        end
      end
    end

    // Tag lines up with the bank response.
    assign owner_tail = owner_q[MemoryLatency-1];

    // ------------------------------------------------------------------------
    // Backward channel.
    // ------------------------------------------------------------------------
    assign narrow_rvalid_o[i] = bank[i].p_valid & (owner_tail == OWN_NARROW);
    assign narrow_rdata_o[i]  = bank[i].p_data;
    assign wide_hit[i]        = bank[i].p_valid & (owner_tail == OWN_WIDE);
    assign ext_hit[i]         = bank[i].p_valid & (owner_tail == OWN_EXT);
    assign bank_rdata[i]      = bank[i].p_data;
  end

  // Wide beats return on all banks together.
  assign wide_rvalid_o     = &wide_hit;
  assign ext_rvalid_o      = &ext_hit;
  // Data is broadcast to both wide sources.
  assign wide_rdata_o.lane = bank_rdata;
  assign ext_rdata_o.lane  = bank_rdata;

endmodule

//--- src/tcdm_bank.sv
// Single-port SRAM bank with byte write enables.
// Always ready; read data and p_valid come one cycle after acceptance.
// Array content is undefined after reset.
`timescale 1ns/1ps

module tcdm_bank import tcdm_pkg::*; #(
  // Words in this bank.
  parameter int unsigned BankWords = 64
) (
  input  logic          clk_i,
  input  logic          rst_i,
  tcdm_bus_if.responder bus
);

  // --------------------------------------------------------------------------
  // Storage.
  // --------------------------------------------------------------------------

  // Word array.
  narrow_data_t mem_q [BankWords];
  // Registered read word.
  narrow_data_t rdata_q;
  // Response strobe.
  logic         pvalid_q;
  // Request taken this cycle.
  logic         accept;

  // No stalls, so every valid is taken.
  assign bus.q_ready = 1'b1;
  assign accept      = bus.q_valid & bus.q_ready;

  // --------------------------------------------------------------------------
  // Write port.
  // --------------------------------------------------------------------------

  // Only strobed bytes change.
  always_ff @(posedge clk_i) begin
    if (accept && bus.q_write) begin
      for (int b = 0; b < NARROW_STRB_W; b++) begin
        if (bus.q_strb[b]) begin
          mem_q[bus.q_addr][8*b +: 8] <= bus.q_data[8*b +: 8];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read port.
  // --------------------------------------------------------------------------

  // Old word is read on a write too.
  // Nobody looks at it then.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= mem_q[bus.q_addr];
    end
  end

  // One response per accepted request.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pvalid_q <= 1'b0;
    end else begin
      pvalid_q <= accept;
    end
  end

  assign bus.p_valid = pvalid_q;
  assign bus.p_data  = rdata_q;

endmodule

//--- src/tcdm_bus_if.sv
// One narrow memory port between the mux and a bank.
// A request is taken when q_valid and q_ready are both high.
// The response follows a fixed latency later; p_data is don't-care for writes.
`timescale 1ns/1ps

interface tcdm_bus_if import tcdm_pkg::*; #(
  // Words per bank, sets the row address width.
  parameter int unsigned BankWords = 64,
  localparam int unsigned AddrW    = $clog2(BankWords)
) ();

  // Request channel.
  logic             q_valid;
  logic [AddrW-1:0] q_addr;
  logic             q_write;
  narrow_data_t     q_data;
  narrow_strb_t     q_strb;
  logic             q_ready;

  // Response channel.
  logic             p_valid;
  narrow_data_t     p_data;

  // Mux side.
  modport requester (
    output q_valid, q_addr, q_write, q_data, q_strb,
    input  q_ready, p_valid, p_data
  );

  // Bank side.
  modport responder (
    input  q_valid, q_addr, q_write, q_data, q_strb,
    output q_ready, p_valid, p_data
  );

endinterface

//--- src/tcdm_pkg.sv
// Bus geometry for the TCDM subsystem.
// The wide word is exactly NR_BANKS narrow words, so lane i always maps to bank i.
// Narrow width must stay a multiple of 8 for the byte strobes.
package tcdm_pkg;

  // --------------------------------------------------------------------------
  // Widths.
  // --------------------------------------------------------------------------

  // One bank word.
  localparam int unsigned NARROW_W      = 32;
  // Banks, and narrow ports, one per bank.
  localparam int unsigned NR_BANKS      = 4;
  // Wide word spans every bank at one row.
  localparam int unsigned WIDE_W        = NARROW_W * NR_BANKS;
  // Byte strobes.
  localparam int unsigned NARROW_STRB_W = NARROW_W / 8;
  localparam int unsigned WIDE_STRB_W   = WIDE_W / 8;

  // --------------------------------------------------------------------------
  // Types.
  // --------------------------------------------------------------------------

  typedef logic [NARROW_W-1:0]      narrow_data_t;
  typedef logic [NARROW_STRB_W-1:0] narrow_strb_t;

  // Wide data, seen as one word or as per-bank lanes.
  // Lane 0 is the least significant narrow word.
  typedef union packed {
    logic [WIDE_W-1:0]           word;
    narrow_data_t [NR_BANKS-1:0] lane;
  } wide_data_u;

  // Wide strobes, split the same way as the data.
  typedef union packed {
    logic [WIDE_STRB_W-1:0]      word;
    narrow_strb_t [NR_BANKS-1:0] lane;
  } wide_strb_u;

endpackage

//--- src/tcdm_subsystem.sv
// TCDM top level with NR_BANKS banks behind the wide/narrow mux.
// Narrow port i reaches bank i only; wide and external ports span one row.
// Read latency is one cycle on every port. Banks never stall.
`timescale 1ns/1ps

module tcdm_subsystem import tcdm_pkg::*; #(
  // Words per bank.
  parameter int unsigned BankWords = 64,
  localparam int unsigned AddrW    = $clog2(BankWords)
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  // Narrow ports.
  input  logic         [NR_BANKS-1:0]            narrow_valid_i,
  input  logic         [NR_BANKS-1:0]            narrow_write_i,
  input  logic         [NR_BANKS-1:0][AddrW-1:0] narrow_addr_i,
  input  narrow_data_t [NR_BANKS-1:0]            narrow_data_i,
  input  narrow_strb_t [NR_BANKS-1:0]            narrow_strb_i,
  output logic         [NR_BANKS-1:0]            narrow_ready_o,
  output logic         [NR_BANKS-1:0]            narrow_rvalid_o,
  output narrow_data_t [NR_BANKS-1:0]            narrow_rdata_o,
  // Wide DMA port.
  input  logic                                   wide_valid_i,
  input  logic                                   wide_write_i,
  input  logic         [AddrW-1:0]               wide_addr_i,
  input  wide_data_u                             wide_data_i,
  input  wide_strb_u                             wide_strb_i,
  output logic                                   wide_ready_o,
  output logic                                   wide_rvalid_o,
  output wide_data_u                             wide_rdata_o,
  // External port.
  input  logic                                   ext_valid_i,
  input  logic                                   ext_write_i,
  input  logic         [AddrW-1:0]               ext_addr_i,
  input  wide_data_u                             ext_data_i,
  input  wide_strb_u                             ext_strb_i,
  output logic                                   ext_ready_o,
  output logic                                   ext_rvalid_o,
  output wide_data_u                             ext_rdata_o
);

  // Matches the bank read register.
  localparam int unsigned MemoryLatency = 1;

  // --------------------------------------------------------------------------
  // Bank buses.
  // --------------------------------------------------------------------------

  tcdm_bus_if #(
    .BankWords (BankWords)
  ) bank_bus [NR_BANKS] ();

  // --------------------------------------------------------------------------
  // Mux.
  // --------------------------------------------------------------------------

  mem_wide_narrow_mux #(
    .BankWords     (BankWords),
    .MemoryLatency (MemoryLatency)
  ) i_mem_wide_narrow_mux (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .narrow_valid_i  (narrow_valid_i),
    .narrow_write_i  (narrow_write_i),
    .narrow_addr_i   (narrow_addr_i),
    .narrow_data_i   (narrow_data_i),
    .narrow_strb_i   (narrow_strb_i),
    .narrow_ready_o  (narrow_ready_o),
    .narrow_rvalid_o (narrow_rvalid_o),
    .narrow_rdata_o  (narrow_rdata_o),
    .wide_valid_i    (wide_valid_i),
    .wide_write_i    (wide_write_i),
    .wide_addr_i     (wide_addr_i),
    .wide_data_i     (wide_data_i),
    .wide_strb_i     (wide_strb_i),
    .wide_ready_o    (wide_ready_o),
    .wide_rvalid_o   (wide_rvalid_o),
    .wide_rdata_o    (wide_rdata_o),
    .ext_valid_i     (ext_valid_i),
    .ext_write_i     (ext_write_i),
    .ext_addr_i      (ext_addr_i),
    .ext_data_i      (ext_data_i),
    .ext_strb_i      (ext_strb_i),
    .ext_ready_o     (ext_ready_o),
    .ext_rvalid_o    (ext_rvalid_o),
    .ext_rdata_o     (ext_rdata_o),
    .bank            (bank_bus)
  );

  // --------------------------------------------------------------------------
  // Banks.
  // --------------------------------------------------------------------------

  // One bank per lane of the wide word.
  for (genvar i = 0; i < NR_BANKS; i++) begin : gen_bank
    tcdm_bank #(
      .BankWords (BankWords)
    ) i_tcdm_bank (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .bus   (bank_bus[i])
    );
  end

endmodule

//--- verification/tb_tcdm_subsystem.sv
// Table-driven testbench for the TCDM subsystem with 64 words per bank.
// Inputs change on the falling edge; outputs are sampled 1 ns later.
// Read expectations come from a byte-level memory model of all banks.
// Only addresses written earlier in the table are read back.
`timescale 1ns/1ps

module tb_tcdm_subsystem import tcdm_pkg::*; ();

  localparam int unsigned BankWords = 64;
  localparam int unsigned AddrW     = $clog2(BankWords);
  localparam logic [31:0] LFSR_SEED = 32'hc8a59c93;
  localparam logic [31:0] LFSR_TAPS = 32'hd0000001;
  // Response mask bits [3:0] are the narrow ports, bit 4 is wide and bit 5 external.
  localparam logic [5:0]  RSP_WIDE  = 6'h10;
  localparam logic [5:0]  RSP_EXT   = 6'h20;

  // One table row holds the stimulus of every port and the expected results.
  typedef struct {
    string                              name;
    logic         [NR_BANKS-1:0]            n_valid;
    logic         [NR_BANKS-1:0]            n_write;
    logic         [NR_BANKS-1:0][AddrW-1:0] n_addr;
    narrow_data_t [NR_BANKS-1:0]            n_data;
    narrow_strb_t [NR_BANKS-1:0]            n_strb;
    logic                               w_valid;
    logic                               w_write;
    logic         [AddrW-1:0]           w_addr;
    wide_data_u                         w_data;
    wide_strb_u                         w_strb;
    logic                               e_valid;
    logic                               e_write;
    logic         [AddrW-1:0]           e_addr;
    wide_data_u                         e_data;
    wide_strb_u                         e_strb;
    logic         [NR_BANKS-1:0]        exp_n_ready;
    logic                               exp_w_ready;
    logic                               exp_e_ready;
    logic         [5:0]                 exp_rsp;
  } row_t;

  // --------------------------------------------------------------------------
  // DUT signals.
  // --------------------------------------------------------------------------

  logic clk_i;
  logic rst_i;
  logic         [NR_BANKS-1:0]            narrow_valid_i, narrow_write_i;
  logic         [NR_BANKS-1:0][AddrW-1:0] narrow_addr_i;
  narrow_data_t [NR_BANKS-1:0]            narrow_data_i, narrow_rdata_o;
  narrow_strb_t [NR_BANKS-1:0]            narrow_strb_i;
  logic         [NR_BANKS-1:0]            narrow_ready_o, narrow_rvalid_o;
  logic             wide_valid_i, wide_write_i, wide_ready_o, wide_rvalid_o;
  logic [AddrW-1:0] wide_addr_i, ext_addr_i;
  wide_data_u       wide_data_i, wide_rdata_o, ext_data_i, ext_rdata_o;
  wide_strb_u       wide_strb_i, ext_strb_i;
  logic             ext_valid_i, ext_write_i, ext_ready_o, ext_rvalid_o;

  // Table, model and pending response expectations.
  row_t                        rows[$];
  row_t                        cur;
  narrow_data_t                model_mem [NR_BANKS][BankWords];
  logic         [5:0]          pend_rsp;
  logic         [NR_BANKS-1:0] pend_n_read;
  narrow_data_t [NR_BANKS-1:0] pend_n_data;
  logic                        pend_w_read, pend_e_read;
  wide_data_u                  pend_w_data, pend_e_data;
  string                       prev_name;
  logic         [31:0]         lfsr_q;
  int                          cycle_cnt;
  int                          timeout_cycles;

  tcdm_subsystem #(
    .BankWords (BankWords)
  ) tcdm_subsystem_i (
    .clk_i, .rst_i,
    .narrow_valid_i, .narrow_write_i, .narrow_addr_i, .narrow_data_i, .narrow_strb_i,
    .narrow_ready_o, .narrow_rvalid_o, .narrow_rdata_o,
    .wide_valid_i, .wide_write_i, .wide_addr_i, .wide_data_i, .wide_strb_i,
    .wide_ready_o, .wide_rvalid_o, .wide_rdata_o,
    .ext_valid_i, .ext_write_i, .ext_addr_i, .ext_data_i, .ext_strb_i,
    .ext_ready_o, .ext_rvalid_o, .ext_rdata_o
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Run limit in cycles is set from the table length.
  initial cycle_cnt = 0;
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: the table did not finish within %0d cycles", timeout_cycles);
      $display("ERRORS FOUND");
      $fatal(1, "Run stopped by timeout");
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers.
  // --------------------------------------------------------------------------

  // Galois LFSR stepped once per bit taken.
  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] v;
    logic         lsb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lsb    = lfsr_q[0];
      v[k]   = lsb;
      lfsr_q = lfsr_q >> 1;
      if (lsb) lfsr_q = lfsr_q ^ LFSR_TAPS;
    end
    return v;
  endfunction

  // All ports idle and nothing expected.
  function automatic row_t idle_row(input string name);
    row_t r;
    r.name        = name;
    r.n_valid     = '0;
    r.n_write     = '0;
    r.n_addr      = '0;
    r.n_data      = '0;
    r.n_strb      = '0;
    r.w_valid     = 1'b0;
    r.w_write     = 1'b0;
    r.w_addr      = '0;
    r.w_data      = '0;
    r.w_strb      = '0;
    r.e_valid     = 1'b0;
    r.e_write     = 1'b0;
    r.e_addr      = '0;
    r.e_data      = '0;
    r.e_strb      = '0;
    r.exp_n_ready = '0;
    r.exp_w_ready = 1'b0;
    r.exp_e_ready = 1'b0;
    r.exp_rsp     = '0;
    return r;
  endfunction

  // Write data is random; read data stays zero.
  task automatic set_narrow(input int i, input logic wr, input int addr,
                            input narrow_strb_t strb);
    cur.n_valid[i] = 1'b1;
    cur.n_write[i] = wr;
    cur.n_addr[i]  = AddrW'(addr);
    cur.n_data[i]  = wr ? narrow_data_t'(rand_bits(NARROW_W)) : '0;
    cur.n_strb[i]  = strb;
  endtask

  task automatic set_wide(input logic wr, input int addr, input wide_strb_u strb);
    cur.w_valid = 1'b1;
    cur.w_write = wr;
    cur.w_addr  = AddrW'(addr);
    cur.w_data  = wr ? rand_bits(WIDE_W) : '0;
    cur.w_strb  = strb;
  endtask

  task automatic set_ext(input logic wr, input int addr, input wide_strb_u strb);
    cur.e_valid = 1'b1;
    cur.e_write = wr;
    cur.e_addr  = AddrW'(addr);
    cur.e_data  = wr ? rand_bits(WIDE_W) : '0;
    cur.e_strb  = strb;
  endtask

  // Expected grants of this row and response mask of the next cycle.
  task automatic add_row(input logic [NR_BANKS-1:0] n_rdy, input logic w_rdy,
                         input logic e_rdy, input logic [5:0] rsp);
    cur.exp_n_ready = n_rdy;
    cur.exp_w_ready = w_rdy;
    cur.exp_e_ready = e_rdy;
    cur.exp_rsp     = rsp;
    rows.push_back(cur);
  endtask

  task automatic build_table();
    wide_strb_u part_strb;
    // Own bank write then read for one narrow port at a time.
    for (int i = 0; i < NR_BANKS; i++) begin
      cur = idle_row($sformatf("t1_write_n%0d", i));
      set_narrow(i, 1'b1, 5 + i, '1);
      add_row(NR_BANKS'(1 << i), 1'b0, 1'b0, 6'(1 << i));
      cur = idle_row($sformatf("t1_read_n%0d", i));
      set_narrow(i, 1'b0, 5 + i, '0);
      add_row(NR_BANKS'(1 << i), 1'b0, 1'b0, 6'(1 << i));
    end
    // Wide write with the narrow lanes read back.
    cur = idle_row("t2_wide_write");
    set_wide(1'b1, 10, '1);
    add_row('0, 1'b1, 1'b0, RSP_WIDE);
    cur = idle_row("t2_narrow_read");
    for (int i = 0; i < NR_BANKS; i++) set_narrow(i, 1'b0, 10, '0);
    add_row('1, 1'b0, 1'b0, 6'h0f);
    // Narrow writes with a wide read back.
    cur = idle_row("t3_narrow_write");
    for (int i = 0; i < NR_BANKS; i++) set_narrow(i, 1'b1, 20, '1);
    add_row('1, 1'b0, 1'b0, 6'h0f);
    cur = idle_row("t3_wide_read");
    set_wide(1'b0, 20, '0);
    add_row('0, 1'b1, 1'b0, RSP_WIDE);
    // Everyone at once; losers hold and win in priority order.
    cur = idle_row("t4_all_valid");
    set_wide(1'b1, 30, '1);
    set_ext(1'b1, 31, '1);
    for (int i = 0; i < NR_BANKS; i++) set_narrow(i, 1'b1, 32, '1);
    add_row('0, 1'b1, 1'b0, RSP_WIDE);
    cur.name    = "t4_ext_granted";
    cur.w_valid = 1'b0;
    add_row('0, 1'b0, 1'b1, RSP_EXT);
    cur.name    = "t4_narrow_granted";
    cur.e_valid = 1'b0;
    add_row('1, 1'b0, 1'b0, 6'h0f);
    cur = idle_row("t4_wide_read");
    set_wide(1'b0, 30, '0);
    add_row('0, 1'b1, 1'b0, RSP_WIDE);
    cur = idle_row("t4_ext_read");
    set_ext(1'b0, 31, '0);
    add_row('0, 1'b0, 1'b1, RSP_EXT);
    cur = idle_row("t4_narrow_read");
    for (int i = 0; i < NR_BANKS; i++) set_narrow(i, 1'b0, 32, '0);
    add_row('1, 1'b0, 1'b0, 6'h0f);
    // Partial external write over a known row blocks the narrow reads once.
    cur = idle_row("t5_ext_init");
    set_ext(1'b1, 40, '1);
    add_row('0, 1'b0, 1'b1, RSP_EXT);
    cur = idle_row("t5_ext_partial");
    part_strb.word = WIDE_STRB_W'(rand_bits(WIDE_STRB_W));
    set_ext(1'b1, 40, part_strb);
    for (int i = 0; i < NR_BANKS; i++) set_narrow(i, 1'b0, 40, '0);
    add_row('0, 1'b0, 1'b1, RSP_EXT);
    cur.name    = "t5_narrow_read";
    cur.e_valid = 1'b0;
    add_row('1, 1'b0, 1'b0, 6'h0f);
    cur = idle_row("t5_wide_read");
    set_wide(1'b0, 40, '0);
    add_row('0, 1'b1, 1'b0, RSP_WIDE);
    // Back-to-back reads with a new owner every cycle.
    cur = idle_row("t6_n0_read");
    set_narrow(0, 1'b0, 5, '0);
    add_row(4'h1, 1'b0, 1'b0, 6'h01);
    cur = idle_row("t6_wide_read");
    set_wide(1'b0, 10, '0);
    add_row('0, 1'b1, 1'b0, RSP_WIDE);
    cur = idle_row("t6_ext_read");
    set_ext(1'b0, 40, '0);
    add_row('0, 1'b0, 1'b1, RSP_EXT);
    cur = idle_row("t6_n2_read");
    set_narrow(2, 1'b0, 7, '0);
    add_row(4'h4, 1'b0, 1'b0, 6'h04);
    cur = idle_row("t6_wide_read2");
    set_wide(1'b0, 20, '0);
    add_row('0, 1'b1, 1'b0, RSP_WIDE);
    cur = idle_row("t6_n3_read");
    set_narrow(3, 1'b0, 8, '0);
    add_row(4'h8, 1'b0, 1'b0, 6'h08);
  endtask

  task automatic drive_row(input row_t r);
    narrow_valid_i = r.n_valid;
    narrow_write_i = r.n_write;
    narrow_addr_i  = r.n_addr;
    narrow_data_i  = r.n_data;
    narrow_strb_i  = r.n_strb;
    wide_valid_i   = r.w_valid;
    wide_write_i   = r.w_write;
    wide_addr_i    = r.w_addr;
    wide_data_i    = r.w_data;
    wide_strb_i    = r.w_strb;
    ext_valid_i    = r.e_valid;
    ext_write_i    = r.e_write;
    ext_addr_i     = r.e_addr;
    ext_data_i     = r.e_data;
    ext_strb_i     = r.e_strb;
  endtask

  // --------------------------------------------------------------------------
  // Memory model.
  // --------------------------------------------------------------------------

  // Strobed bytes take the new data.
  function automatic narrow_data_t merge_bytes(input narrow_data_t old_word,
                                               input narrow_data_t new_word,
                                               input narrow_strb_t strb);
    narrow_data_t res;
    res = old_word;
    for (int b = 0; b < NARROW_STRB_W; b++) begin
      if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // One row across all banks; read data is taken before the write.
  task automatic access_row(input logic wr, input logic [AddrW-1:0] addr,
                            input wide_data_u data, input wide_strb_u strb,
                            output logic rd, output wide_data_u rdata);
    for (int b = 0; b < NR_BANKS; b++) begin
      rdata.lane[b] = model_mem[b][addr];
      if (wr) begin
        model_mem[b][addr] = merge_bytes(model_mem[b][addr], data.lane[b],
                                         strb.lane[b]);
      end
    end
    rd = ~wr;
  endtask

  // The expected grants of a row tell which requests were accepted.
  task automatic update_model(input row_t r);
    pend_rsp    = r.exp_rsp;
    pend_n_read = '0;
    pend_w_read = 1'b0;
    pend_e_read = 1'b0;
    if (r.exp_w_ready) begin
      access_row(r.w_write, r.w_addr, r.w_data, r.w_strb, pend_w_read, pend_w_data);
    end
    if (r.exp_e_ready) begin
      access_row(r.e_write, r.e_addr, r.e_data, r.e_strb, pend_e_read, pend_e_data);
    end
    for (int i = 0; i < NR_BANKS; i++) begin
      if (r.exp_n_ready[i] && r.n_write[i]) begin
        model_mem[i][r.n_addr[i]] = merge_bytes(model_mem[i][r.n_addr[i]], r.n_data[i],
                                                r.n_strb[i]);
      end else if (r.exp_n_ready[i]) begin
        pend_n_read[i] = 1'b1;
        pend_n_data[i] = model_mem[i][r.n_addr[i]];
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Compare tasks.
  // --------------------------------------------------------------------------

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Grant mismatch on %s", name);
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Response valid mismatch on %s", name);
    end
  endtask

  task automatic check_narrow(input string name, input narrow_data_t exp,
                              input narrow_data_t act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Narrow data mismatch on %s", name);
    end
  endtask

  task automatic check_wide(input string name, input wide_data_u exp, input wide_data_u act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp.word, act.word);
      $display("ERRORS FOUND");
      $fatal(1, "Wide data mismatch on %s", name);
    end
  endtask

  task automatic check_readies(input row_t r);
    for (int i = 0; i < NR_BANKS; i++) begin
      check_ready($sformatf("%s narrow_ready_o[%0d]", r.name, i), r.exp_n_ready[i],
                  narrow_ready_o[i]);
    end
    check_ready({r.name, " wide_ready_o"}, r.exp_w_ready, wide_ready_o);
    check_ready({r.name, " ext_ready_o"}, r.exp_e_ready, ext_ready_o);
  endtask

  // Responses to the row accepted one cycle earlier.
  task automatic check_responses(input string name);
    for (int i = 0; i < NR_BANKS; i++) begin
      check_valid($sformatf("%s narrow_rvalid_o[%0d]", name, i), pend_rsp[i],
                  narrow_rvalid_o[i]);
      if (pend_rsp[i] && pend_n_read[i]) begin
        check_narrow($sformatf("%s narrow_rdata_o[%0d]", name, i), pend_n_data[i],
                     narrow_rdata_o[i]);
      end
    end
    check_valid({name, " wide_rvalid_o"}, pend_rsp[4], wide_rvalid_o);
    if (pend_rsp[4] && pend_w_read) begin
      check_wide({name, " wide_rdata_o"}, pend_w_data, wide_rdata_o);
    end
    check_valid({name, " ext_rvalid_o"}, pend_rsp[5], ext_rvalid_o);
    if (pend_rsp[5] && pend_e_read) begin
      check_wide({name, " ext_rdata_o"}, pend_e_data, ext_rdata_o);
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence.
  // --------------------------------------------------------------------------

  initial begin
    lfsr_q = LFSR_SEED;
    build_table();
    timeout_cycles = rows.size() + 20;
    drive_row(idle_row("reset"));
    rst_i     = 1'b1;
    pend_rsp  = '0;
    prev_name = "reset";
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    foreach (rows[k]) begin
      @(negedge clk_i);
      drive_row(rows[k]);
      #1;
      check_responses(prev_name);
      check_readies(rows[k]);
      update_model(rows[k]);
      prev_name = rows[k].name;
    end
    // Drain the last response.
    @(negedge clk_i);
    drive_row(idle_row("drain"));
    #1;
    check_responses(prev_name);
    $display("NO ERRORS");
    $finish;
  end

endmodule
